/* hw/cam_mask_pkg.sv */
package cam_mask_pkg;

  localparam int NUM_CHAN    = 3;   // y, cr, cb
  localparam int MASK_WORD_W = 16;  // mask bits per output word

  typedef logic [7:0]  cam_byte_t;  // raw camera bus byte
  typedef logic [7:0]  chan_t;      // one ycrcb channel value
  typedef logic [10:0] hcount_t;
  typedef logic [9:0]  vcount_t;

  // rgb565 as it arrives from the camera, red in the msbs
  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  // one rebuilt pixel with its frame position
  typedef struct packed {
    rgb565_t pixel;
    hcount_t hcount;
    vcount_t vcount;
    logic    frame_end;  // last pixel of the frame
  } pixel_beat_t;

  // converted pixel, chan[0] = y, chan[1] = cr, chan[2] = cb
  typedef struct packed {
    chan_t [NUM_CHAN-1:0] chan;
    logic                 frame_end;
  } ycc_beat_t;

  // inclusive bounds for one channel
  typedef struct packed {
    chan_t lower;
    chan_t upper;
  } window_t;

  typedef window_t [NUM_CHAN-1:0] window_cfg_t;  // same indexing as ycc_beat_t

  typedef struct packed {
    logic [MASK_WORD_W-1:0] bits;       // bit 0 is the earliest pixel
    logic                   frame_end;  // set on the last word of a frame
  } mask_word_t;

endpackage

/* hw/channel_window.sv */
`timescale 1ns/1ps

module channel_window (
  input  logic                  clk_camera,
  input  logic                  recent_reset,
  input  logic                  valid_i,
  input  cam_mask_pkg::chan_t   value_i,
  input  cam_mask_pkg::window_t window_i,
  output logic                  in_window_o
);

  logic above_lower;
  logic below_upper;

  // both bounds inclusive, an inverted window never matches
  assign above_lower = (value_i >= window_i.lower);
  assign below_upper = (value_i <= window_i.upper);

  // flag holds between pixels, only updated on a valid beat
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      in_window_o <= 1'b0;
    end else if (valid_i) begin
      in_window_o <= above_lower & below_upper;
    end
  end

endmodule

/* hw/pixel_reconstruct.sv */
`timescale 1ns/1ps

module pixel_reconstruct #(
  parameter int FRAME_WIDTH  = 1280,
  parameter int FRAME_HEIGHT = 720
) (
  input  logic                      clk_camera,
  input  logic                      recent_reset,
  input  cam_mask_pkg::cam_byte_t   camera_d_i,
  input  logic                      cam_pclk_i,
  input  logic                      cam_hsync_i,
  input  logic                      cam_vsync_i,
  output logic                      pix_valid_o,
  output cam_mask_pkg::pixel_beat_t pix_o
);
  import cam_mask_pkg::*;

  localparam hcount_t LAST_H = hcount_t'(FRAME_WIDTH - 1);
  localparam vcount_t LAST_V = vcount_t'(FRAME_HEIGHT - 1);

  cam_byte_t  data_meta, data_sync;  // two flops on the data bus
  logic [1:0] pclk_sync;             // [1] is the settled copy
  logic [1:0] hsync_sync;
  logic [1:0] vsync_sync;
  logic       pclk_prev, hsync_prev;
  logic       pclk_rise, hsync_fall;
  logic       second_byte;           // next byte taken closes a pixel
  cam_byte_t  first_byte;
  hcount_t    hcount;
  vcount_t    vcount;

  always_ff @(posedge clk_camera) begin
    data_meta <= camera_d_i;
    data_sync <= data_meta;
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pclk_sync  <= '0;
      hsync_sync <= '0;
      vsync_sync <= '0;
      pclk_prev  <= 1'b0;
      hsync_prev <= 1'b0;
    end else begin
      pclk_sync  <= {pclk_sync[0], cam_pclk_i};
      hsync_sync <= {hsync_sync[0], cam_hsync_i};
      vsync_sync <= {vsync_sync[0], cam_vsync_i};
      pclk_prev  <= pclk_sync[1];
      hsync_prev <= hsync_sync[1];
    end
  end

  assign pclk_rise  = pclk_sync[1] & ~pclk_prev;
  assign hsync_fall = ~hsync_sync[1] & hsync_prev;  // end of a line

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      second_byte <= 1'b0;
      hcount      <= '0;
      vcount      <= '0;
      pix_valid_o <= 1'b0;
    end else begin
      pix_valid_o <= 1'b0;
      if (!hsync_sync[1]) begin  // blanking, restart the line
        second_byte <= 1'b0;
        hcount      <= '0;
      end else if (pclk_rise) begin
        second_byte <= ~second_byte;
        if (second_byte) begin
          pix_valid_o <= 1'b1;
          hcount      <= hcount + 1'b1;
        end
      end
      if (vsync_sync[1]) vcount <= '0;
      else if (hsync_fall) vcount <= vcount + 1'b1;
    end
  end

  // byte 0 = r[4:0] g[5:3], byte 1 = g[2:0] b[4:0]
  always_ff @(posedge clk_camera) begin
    if (hsync_sync[1] && pclk_rise) begin
      if (!second_byte) begin
        first_byte <= data_sync;
      end else begin
        pix_o.pixel     <= rgb565_t'({first_byte, data_sync});
        pix_o.hcount    <= hcount;
        pix_o.vcount    <= vcount;
        pix_o.frame_end <= (hcount == LAST_H) && (vcount == LAST_V);
      end
    end
  end

endmodule

/* hw/ycrcb_convert.sv */
`timescale 1ns/1ps

module ycrcb_convert (
  input  logic                      clk_camera,
  input  logic                      recent_reset,
  input  logic                      pix_valid_i,
  input  cam_mask_pkg::pixel_beat_t pix_i,
  output logic                      ycc_valid_o,
  output cam_mask_pkg::ycc_beat_t   ycc_o
);
  import cam_mask_pkg::*;

  // rows are y, cr, cb; columns weight r, g, b
  localparam int COEF [NUM_CHAN][NUM_CHAN] = '{
    '{ 66, 129,  25},
    '{112, -94, -18},
    '{-38, -74, 112}
  };
  localparam int OFFSET [NUM_CHAN] = '{16, 128, 128};

  logic [1:0]         valid_q;      // stages 1 and 2, stage 3 is ycc_valid_o
  logic [1:0]         frame_end_q;
  chan_t              rgb_q [NUM_CHAN];             // widened r, g, b
  logic signed [17:0] prod_q [NUM_CHAN][NUM_CHAN];  // |product| stays below 2^15
  int                 acc [NUM_CHAN];
  chan_t              chan_clip [NUM_CHAN];

  function automatic chan_t clip8(input int v);
    if (v < 0) return '0;
    else if (v > 255) return 8'd255;
    else return chan_t'(v);
  endfunction

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      valid_q     <= '0;
      ycc_valid_o <= 1'b0;
    end else begin
      valid_q     <= {valid_q[0], pix_valid_i};
      ycc_valid_o <= valid_q[1];
    end
  end

  // stage 3 input, sum of products then arithmetic shift and offset
  always_comb begin
    for (int c = 0; c < NUM_CHAN; c++) begin
      acc[c] = (int'(prod_q[c][0]) + int'(prod_q[c][1]) + int'(prod_q[c][2])) >>> 8;
      chan_clip[c] = clip8(acc[c] + OFFSET[c]);
    end
  end

  always_ff @(posedge clk_camera) begin
    // stage 1, zero-fill the low bits up to 8
    rgb_q[0]       <= {pix_i.pixel.red, 3'b000};
    rgb_q[1]       <= {pix_i.pixel.green, 2'b00};
    rgb_q[2]       <= {pix_i.pixel.blue, 3'b000};
    frame_end_q[0] <= pix_i.frame_end;
    // stage 2
    for (int c = 0; c < NUM_CHAN; c++) begin
      for (int k = 0; k < NUM_CHAN; k++) begin
        prod_q[c][k] <= 18'(COEF[c][k] * int'(rgb_q[k]));
      end
    end
    frame_end_q[1] <= frame_end_q[0];
    // stage 3
    for (int c = 0; c < NUM_CHAN; c++) begin
      ycc_o.chan[c] <= chan_clip[c];
    end
    ycc_o.frame_end <= frame_end_q[1];
  end

endmodule

/* hw/mask_packer.sv */
`timescale 1ns/1ps

module mask_packer #(
  parameter int FRAME_WIDTH  = 1280,
  parameter int FRAME_HEIGHT = 720
) (
  input  logic                              clk_camera,
  input  logic                              recent_reset,
  input  logic                              flag_valid_i,
  input  logic [cam_mask_pkg::NUM_CHAN-1:0] flags_i,
  input  logic                              frame_end_i,
  output logic                              word_valid_o,
  input  logic                              word_ready_i,
  output cam_mask_pkg::mask_word_t          word_o,
  output logic                              overflow_o
);
  import cam_mask_pkg::*;

  localparam int FIFO_DEPTH      = 4;
  localparam int PTR_W           = $clog2(FIFO_DEPTH);
  localparam int CNT_W           = $clog2(MASK_WORD_W);
  localparam int WORDS_PER_FRAME = FRAME_WIDTH * FRAME_HEIGHT / MASK_WORD_W;

  // a line must end on a word boundary or frame_end falls inside a word
  if (FRAME_WIDTH % MASK_WORD_W != 0 || WORDS_PER_FRAME < 1) begin : g_frame_check
    $error("frame width must be a nonzero multiple of the mask word width");
  end

  logic [CNT_W-1:0]       bit_cnt;
  logic [MASK_WORD_W-2:0] acc_bits;   // all but the last bit of the open word
  logic                   mask_bit;
  logic                   done_q;     // done_word is complete this cycle
  mask_word_t             done_word;
  mask_word_t             fifo_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]       wr_ptr, rd_ptr;
  logic [PTR_W:0]         count;
  logic                   full, push, pop;

  assign mask_bit = &flags_i;  // pixel passes only inside all three windows

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      bit_cnt <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (flag_valid_i) begin
        bit_cnt <= bit_cnt + 1'b1;  // wraps after MASK_WORD_W bits
        done_q  <= (bit_cnt == CNT_W'(MASK_WORD_W - 1));
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (flag_valid_i) begin
      if (bit_cnt == CNT_W'(MASK_WORD_W - 1)) begin
        done_word.bits      <= {mask_bit, acc_bits};
        done_word.frame_end <= frame_end_i;  // last bit of the frame closes its word
      end else begin
        acc_bits[bit_cnt] <= mask_bit;
      end
    end
  end

  // output queue; a word completing while full is dropped
  assign full         = (count == FIFO_DEPTH);
  assign push         = done_q & ~full;
  assign word_valid_o = (count != '0);
  assign pop          = word_valid_o & word_ready_i;
  assign word_o       = fifo_mem[rd_ptr];  // head entry, stable until popped

  always_ff @(posedge clk_camera) begin
    if (push) fifo_mem[wr_ptr] <= done_word;
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (done_q && full) overflow_o <= 1'b1;  // sticky until reset
    end
  end

endmodule

/* hw/camera_mask_top.sv */
`timescale 1ns/1ps

module camera_mask_top #(
  parameter int FRAME_WIDTH  = 1280,
  parameter int FRAME_HEIGHT = 720
) (
  input  logic                      clk_camera,
  input  logic                      recent_reset,
  input  cam_mask_pkg::cam_byte_t   camera_d_i,
  input  logic                      cam_pclk_i,
  input  logic                      cam_hsync_i,
  input  logic                      cam_vsync_i,
  input  cam_mask_pkg::window_cfg_t window_cfg_i,  // hold stable within a frame
  output logic                      word_valid_o,
  input  logic                      word_ready_i,
  output cam_mask_pkg::mask_word_t  word_o,
  output logic                      overflow_o
);
  import cam_mask_pkg::*;

  pixel_beat_t         pix_beat;
  logic                pix_valid;
  ycc_beat_t           ycc_beat;
  logic                ycc_valid;
  logic [NUM_CHAN-1:0] flags;           // one per channel, 1 = inside window
  logic                flag_valid;      // lines up with flags
  logic                flag_frame_end;

  pixel_reconstruct #(
    .FRAME_WIDTH (FRAME_WIDTH),
    .FRAME_HEIGHT(FRAME_HEIGHT)
  ) pixel_reconstruct_i (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .camera_d_i  (camera_d_i),
    .cam_pclk_i  (cam_pclk_i),
    .cam_hsync_i (cam_hsync_i),
    .cam_vsync_i (cam_vsync_i),
    .pix_valid_o (pix_valid),
    .pix_o       (pix_beat)
  );

  ycrcb_convert ycrcb_convert_i (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .pix_valid_i (pix_valid),
    .pix_i       (pix_beat),
    .ycc_valid_o (ycc_valid),
    .ycc_o       (ycc_beat)
  );

  for (genvar c = 0; c < NUM_CHAN; c++) begin : g_chan
    channel_window channel_window_i (
      .clk_camera  (clk_camera),
      .recent_reset(recent_reset),
      .valid_i     (ycc_valid),
      .value_i     (ycc_beat.chan[c]),
      .window_i    (window_cfg_i[c]),
      .in_window_o (flags[c])
    );
    // channel 0 carries valid and frame_end through the window stage
    if (c == 0) begin : g_side
      always_ff @(posedge clk_camera) begin
        if (recent_reset) flag_valid <= 1'b0;
        else flag_valid <= ycc_valid;
      end
      always_ff @(posedge clk_camera) begin
        flag_frame_end <= ycc_beat.frame_end;
      end
    end
  end

  mask_packer #(
    .FRAME_WIDTH (FRAME_WIDTH),
    .FRAME_HEIGHT(FRAME_HEIGHT)
  ) mask_packer_i (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .flag_valid_i(flag_valid),
    .flags_i     (flags),
    .frame_end_i (flag_frame_end),
    .word_valid_o(word_valid_o),
    .word_ready_i(word_ready_i),
    .word_o      (word_o),
    .overflow_o  (overflow_o)
  );

endmodule

/* tb/camera_mask_assertions.sv */
`timescale 1ns/1ps

module camera_mask_assertions (
  input logic                     clk_camera,
  input logic                     recent_reset,
  input logic                     word_valid_i,
  input logic                     word_ready_i,
  input cam_mask_pkg::mask_word_t word_i,
  input logic                     overflow_i
);

  int unsigned fail_count = 0;  // failures seen by any property below

  // a stalled word stays put until taken
  hold_word: assert property (@(posedge clk_camera) disable iff (recent_reset)
    word_valid_i && !word_ready_i |=> word_valid_i && $stable(word_i))
    else begin
      fail_count++;
      $error("word_o changed or word_valid_o dropped while ready was low");
    end

  // overflow only clears through reset
  sticky_overflow: assert property (@(posedge clk_camera) disable iff (recent_reset)
    overflow_i |=> overflow_i)
    else begin
      fail_count++;
      $error("overflow_o fell without reset");
    end

  // queue empty right after reset
  empty_after_reset: assert property (@(posedge clk_camera)
    recent_reset |=> !word_valid_i)
    else begin
      fail_count++;
      $error("word_valid_o high in the cycle after reset");
    end

endmodule

bind camera_mask_top camera_mask_assertions camera_mask_assertions_i (
  .clk_camera  (clk_camera),
  .recent_reset(recent_reset),
  .word_valid_i(word_valid_o),
  .word_ready_i(word_ready_i),
  .word_i      (word_o),
  .overflow_i  (overflow_o)
);

/* tb/tb_camera_mask.sv */
`timescale 1ns/1ps

module tb_camera_mask;
  import cam_mask_pkg::*;

  localparam int FRAME_W      = 32;
  localparam int FRAME_H      = 4;
  localparam int NUM_FRAMES   = 4;                         // frames in the vector file
  localparam int PIXELS       = FRAME_W * FRAME_H;
  localparam int WORDS        = PIXELS / MASK_WORD_W;      // 8 words per frame
  localparam int PCLK_HALF    = 4;                         // clk cycles per pclk phase
  localparam int LINE_GAP     = 16;
  localparam int WORD_TIMEOUT = 2000;                      // cycles allowed per awaited event

  logic        clk_camera = 1'b0;
  logic        recent_reset;
  cam_byte_t   camera_d_i;
  logic        cam_pclk_i, cam_hsync_i, cam_vsync_i;
  window_cfg_t window_cfg_i;
  logic        word_valid_o, word_ready_i, overflow_o;
  mask_word_t  word_o;

  logic [15:0] vec_pix [NUM_FRAMES][PIXELS];   // rgb565 in raster order
  logic [15:0] vec_words [NUM_FRAMES][WORDS];  // expected mask bits per word
  window_cfg_t vec_cfg;
  mask_word_t  got_q[$];
  mask_word_t  exp_q[$];
  logic [15:0] lfsr_state = 16'd11318;
  int          fd;

  camera_mask_top #(.FRAME_WIDTH(FRAME_W), .FRAME_HEIGHT(FRAME_H)) camera_mask_top_i (.*);

  always #5 clk_camera = ~clk_camera;

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input mask_word_t got, input mask_word_t exp);
    if (got !== exp)
      fail_now($sformatf("[ERROR] %s got 0x%05h expected 0x%05h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_now($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic next_random_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic int clip_byte(input int v);
    return (v < 0) ? 0 : (v > 255) ? 255 : v;
  endfunction

  // reference conversion on the zero-filled 8 bit channels
  function automatic logic pixel_passes(input rgb565_t p, input window_cfg_t cfg);
    int r, g, b;
    int ycc [NUM_CHAN];
    r = int'(p.red) << 3;
    g = int'(p.green) << 2;
    b = int'(p.blue) << 3;
    ycc[0] = clip_byte(16 + ((66 * r + 129 * g + 25 * b) >>> 8));
    ycc[1] = clip_byte(128 + ((112 * r - 94 * g - 18 * b) >>> 8));
    ycc[2] = clip_byte(128 + ((-38 * r - 74 * g + 112 * b) >>> 8));
    for (int c = 0; c < NUM_CHAN; c++) begin
      if (ycc[c] < int'(cfg[c].lower) || ycc[c] > int'(cfg[c].upper)) return 1'b0;
    end
    return 1'b1;
  endfunction

  function automatic mask_word_t model_word(input int f, input int w, input window_cfg_t cfg);
    mask_word_t m;
    for (int i = 0; i < MASK_WORD_W; i++) begin
      m.bits[i] = pixel_passes(rgb565_t'(vec_pix[f][w * MASK_WORD_W + i]), cfg);
    end
    m.frame_end = (w == WORDS - 1);  // only the last word of a frame
    return m;
  endfunction

  task automatic read_hex(output logic [15:0] v);
    if ($fscanf(fd, "%h", v) != 1) fail_now("vector file ended early or holds a bad value");
  endtask

  // pclk low for PCLK_HALF cycles with the byte set up, then high
  task automatic send_byte(input cam_byte_t b);
    @(negedge clk_camera);
    camera_d_i = b;
    cam_pclk_i = 1'b0;
    repeat (PCLK_HALF) @(negedge clk_camera);
    cam_pclk_i = 1'b1;
    repeat (PCLK_HALF - 1) @(negedge clk_camera);
  endtask

  task automatic send_frame(input int f);
    @(negedge clk_camera);
    cam_vsync_i = 1'b1;  // vsync pulse clears vcount
    repeat (8) @(negedge clk_camera);
    cam_vsync_i = 1'b0;
    repeat (8) @(negedge clk_camera);
    for (int y = 0; y < FRAME_H; y++) begin
      cam_hsync_i = 1'b1;
      for (int x = 0; x < FRAME_W; x++) begin
        send_byte(vec_pix[f][y * FRAME_W + x][15:8]);  // r and upper g first
        send_byte(vec_pix[f][y * FRAME_W + x][7:0]);
      end
      @(negedge clk_camera);
      cam_pclk_i  = 1'b0;
      cam_hsync_i = 1'b0;  // falling hsync bumps vcount
      repeat (LINE_GAP) @(negedge clk_camera);
    end
  endtask

  // ready is decided at the falling edge, a word seen with ready is popped at the next rise
  task automatic collect_words(input int n, input bit random_ready);
    int waited;
    waited = 0;
    got_q.delete();
    while (got_q.size() < n) begin
      @(negedge clk_camera);
      word_ready_i = random_ready ? next_random_bit() : 1'b1;
      if (word_valid_o && word_ready_i) begin
        got_q.push_back(word_o);
        waited = 0;
      end else begin
        waited++;
        if (waited > WORD_TIMEOUT)
          fail_now($sformatf("timeout: word %0d of %0d never arrived", got_q.size(), n));
      end
    end
    @(negedge clk_camera);
    word_ready_i = 1'b0;
  endtask

  task automatic compare_queues();
    foreach (exp_q[i]) check_word($sformatf("word_o[%0d]", i), got_q[i], exp_q[i]);
  endtask

  task automatic run_frame(input int f, input bit random_ready);
    exp_q.delete();
    for (int w = 0; w < WORDS; w++) exp_q.push_back(model_word(f, w, window_cfg_i));
    fork
      send_frame(f);
      collect_words(WORDS, random_ready);
    join
    compare_queues();
  endtask

  initial begin
    int          waited;
    logic [15:0] val;
    string       hdr;
    recent_reset = 1'b1;
    camera_d_i   = '0;
    cam_pclk_i   = 1'b0;
    cam_hsync_i  = 1'b0;
    cam_vsync_i  = 1'b0;
    word_ready_i = 1'b0;
    window_cfg_i = {NUM_CHAN{16'h00FF}};  // every window 0 to 255
    fd = $fopen("tb/camera_mask_vectors.txt", "r");
    if (fd == 0) fail_now("cannot open tb/camera_mask_vectors.txt");
    if ($fgets(hdr, fd) == 0 || $fgets(hdr, fd) == 0) fail_now("vector file header missing");
    for (int c = 0; c < NUM_CHAN; c++) begin
      read_hex(val);
      vec_cfg[c].lower = val[7:0];
      read_hex(val);
      vec_cfg[c].upper = val[7:0];
    end
    for (int f = 0; f < NUM_FRAMES; f++) begin
      for (int p = 0; p < PIXELS; p++) read_hex(vec_pix[f][p]);
      for (int w = 0; w < WORDS; w++) read_hex(vec_words[f][w]);
    end
    $fclose(fd);
    repeat (16) @(negedge clk_camera);
    recent_reset = 1'b0;
    repeat (32) begin  // idle bus, nothing may come out
      @(negedge clk_camera);
      check_flag("word_valid_o", word_valid_o, 1'b0);
      check_flag("overflow_o", overflow_o, 1'b0);
    end
    run_frame(0, 1'b0);  // open windows, all ones
    window_cfg_i = vec_cfg;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      for (int w = 0; w < WORDS; w++) begin
        if (model_word(f, w, vec_cfg).bits !== vec_words[f][w])
          fail_now($sformatf("vector file word %0d of frame %0d disagrees with the conversion rules",
                             w, f));
      end
    end
    for (int f = 0; f < NUM_FRAMES; f++) run_frame(f, 1'b0);
    check_flag("overflow_o", overflow_o, 1'b0);
    for (int f = 0; f < NUM_FRAMES; f++) run_frame(f, 1'b1);  // random back-pressure
    check_flag("overflow_o", overflow_o, 1'b0);
    send_frame(3);  // ready low the whole frame
    waited = 0;
    while (overflow_o !== 1'b1) begin
      @(negedge clk_camera);
      waited++;
      if (waited > WORD_TIMEOUT) fail_now("timeout: overflow_o never rose with ready held low");
    end
    exp_q.delete();
    for (int w = 0; w < 4; w++) exp_q.push_back(model_word(3, w, vec_cfg));
    collect_words(4, 1'b0);
    compare_queues();
    repeat (64) begin  // the other four words were dropped
      @(negedge clk_camera);
      check_flag("word_valid_o", word_valid_o, 1'b0);
    end
    check_flag("overflow_o", overflow_o, 1'b1);
    run_frame(0, 1'b0);
    check_flag("overflow_o", overflow_o, 1'b1);  // sticky
    if (camera_mask_top_i.camera_mask_assertions_i.fail_count == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      fail_now("bound assertions on the output stream failed during the run");
    end
  end

endmodule

/* tb/camera_mask_vectors.txt */
# line 3: window bounds y_lo y_hi cr_lo cr_hi cb_lo cb_hi, then per frame 8 rows of 16 rgb565
# pixels in raster order and one row of 8 expected mask words, bit 0 = first pixel of the word
3C 64 C8 FF 50 6E
F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
F800 0000 F800 0000 F800 0000 F800 0000 F800 0000 F800 0000 F800 0000 F800 0000
0000 F800 0000 F800 0000 F800 0000 F800 0000 F800 0000 F800 0000 F800 0000 F800
F800 F800 F800 F800 F800 F800 F800 F800 FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
001F 001F 001F 001F 001F 001F 001F 001F F800 F800 F800 F800 F800 F800 F800 F800
F800 07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0
8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 F800
FFFF 0000 5555 AAAA 00FF FF00 0001 8000
F800 F800 0000 0000 F800 F800 0000 0000 F800 F800 0000 0000 F800 F800 0000 0000
0000 0000 F800 F800 0000 0000 F800 F800 0000 0000 F800 F800 0000 0000 F800 F800
F800 F800 F800 F800 0000 0000 0000 0000 F800 F800 F800 F800 0000 0000 0000 0000
FFFF FFFF FFFF FFFF F800 F800 F800 F800 FFFF FFFF FFFF FFFF F800 F800 F800 F800
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0 07E0
001F 001F 001F 001F 001F 001F 001F 001F 001F 001F 001F 001F 001F 001F 001F 001F
F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800
3333 CCCC 0F0F F0F0 0000 0000 0000 FFFF
001F 001F 001F F800 001F 001F 001F 001F 001F 001F 001F 001F 001F 001F 001F 001F
0000 0000 0000 0000 0000 0000 0000 F800 0000 0000 0000 0000 0000 0000 0000 0000
F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 07E0 07E0 07E0 07E0
8000 8000 8000 8000 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800
F800 0000 0000 0000 F800 0000 0000 0000 F800 0000 0000 0000 F800 0000 0000 0000
0000 0000 0000 F800 0000 0000 0000 F800 0000 0000 0000 F800 0000 0000 0000 F800
F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0008 0080 0FFF FFF0 1111 8888 FFFF 0000
8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000
F800 FFFF F800 FFFF F800 FFFF F800 FFFF F800 FFFF F800 FFFF F800 FFFF F800 FFFF
07E0 F800 07E0 F800 07E0 F800 07E0 F800 07E0 F800 07E0 F800 07E0 F800 07E0 F800
F800 F800 F800 F800 F800 F800 F800 F800 0000 F800 F800 F800 F800 F800 F800 F800
F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800
F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 FFFF
FFFF F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800 F800
F800 FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF F800
0000 5555 AAAA FEFF FFFF 7FFF FFFE 8001

/* sim.f */
hw/cam_mask_pkg.sv
hw/channel_window.sv
hw/pixel_reconstruct.sv
hw/ycrcb_convert.sv
hw/mask_packer.sv
hw/camera_mask_top.sv
tb/camera_mask_assertions.sv
tb/tb_camera_mask.sv

/* Bender.yml */
package:
  name: camera_mask

sources:
  # design, package first
  - files:
      - hw/cam_mask_pkg.sv
      - hw/channel_window.sv
      - hw/pixel_reconstruct.sv
      - hw/ycrcb_convert.sv
      - hw/mask_packer.sv
      - hw/camera_mask_top.sv

  # testbench, top module tb_camera_mask
  - target: test
    files:
      - tb/camera_mask_assertions.sv
      - tb/tb_camera_mask.sv
